//--- compile.f
vga_pkg.sv
vga_timing.sv
line_fetch.sv
line_buffer.sv
vga_framebuffer.sv
vga_framebuffer_props.sv
tb_vga_framebuffer.sv

//--- line_buffer.sv
`timescale 1ns/100ps

module line_buffer
  import vga_pkg::*;
#(
  parameter int H_ACTIVE = 640
) (
  input  logic                        sys_clock,
  input  logic                        vga_clock,
  input  logic                        reset_n,
  input  logic                        wr_en,
  input  logic                        wr_bank,
  input  logic [$clog2(H_ACTIVE)-1:0] wr_col,
  input  rgb_pixel_t                  wr_pixel,
  input  logic                        rd_en,
  input  logic                        rd_bank,
  input  logic [$clog2(H_ACTIVE)-1:0] rd_col,
  output rgb_pixel_t                  pixel
);

  // one bank per row, fetch fills one while display reads the other
  rgb_pixel_t mem [2][H_ACTIVE];

  always_ff @(posedge sys_clock) begin
    if (wr_en) mem[wr_bank][wr_col] <= wr_pixel;
  end

  // ****************************************
  // display read port
  // ****************************************

  always_ff @(posedge vga_clock or negedge reset_n) begin
    if (!reset_n) begin
      pixel <= BLACK;
    end else if (rd_en) begin
      pixel <= mem[rd_bank][rd_col];
    end else begin
      pixel <= BLACK;  // black in blanking
    end
  end

endmodule

//--- line_fetch.sv
`timescale 1ns/100ps

module line_fetch
  import vga_pkg::*;
#(
  parameter int          H_ACTIVE = 640,
  parameter int          V_ACTIVE = 480,
  parameter logic [31:0] VIDMEM   = 32'h00c00000
) (
  input  logic                        sys_clock,
  input  logic                        reset_n,
  input  logic                        line_toggle,
  input  logic                        frame_toggle,
  input  logic                        bus_wait,
  input  rgb_pixel_t                  data,
  output logic                        bus_read,
  output logic [31:0]                 address,
  output logic                        wr_en,
  output logic                        wr_bank,
  output logic [$clog2(H_ACTIVE)-1:0] wr_col,
  output rgb_pixel_t                  wr_pixel
);

  localparam int              COL_W    = $clog2(H_ACTIVE);
  localparam int              ROW_W    = $clog2(V_ACTIVE + 1);
  localparam logic [COL_W-1:0] LAST_COL = COL_W'(H_ACTIVE - 1);

  logic [2:0]       line_sync;
  logic [2:0]       frame_sync;
  logic             line_edge;
  logic             frame_edge;
  logic             pend_line;
  logic             pend_frame;
  logic             take_line;
  logic             take_frame;
  fetch_state_t     state;
  fetch_state_t     state_next;
  logic [ROW_W-1:0] row;
  logic [ROW_W-1:0] row_next;
  logic [ROW_W-1:0] row_inc;
  logic [COL_W-1:0] col;
  logic [COL_W-1:0] col_next;
  logic             bank;
  logic             bank_next;
  logic [31:0]      address_next;
  logic             wr_en_next;

  // byte address of pixel 0 of a row
  function automatic logic [31:0] row_address(input logic [ROW_W-1:0] r);
    row_address = VIDMEM + PIXEL_BYTES * 32'(H_ACTIVE) * 32'(r);
  endfunction

  // ****************************************
  // toggle synchronizers
  // ****************************************

  always_ff @(posedge sys_clock or negedge reset_n) begin
    if (!reset_n) begin
      line_sync  <= '0;
      frame_sync <= '0;
      pend_line  <= 1'b0;
      pend_frame <= 1'b0;
    end else begin
      line_sync  <= {line_sync[1:0], line_toggle};
      frame_sync <= {frame_sync[1:0], frame_toggle};
      pend_frame <= (pend_frame & ~take_frame) | frame_edge;
      pend_line  <= (pend_line & ~take_line & ~take_frame) | line_edge;  // frame wins
    end
  end

  assign line_edge  = line_sync[2] ^ line_sync[1];
  assign frame_edge = frame_sync[2] ^ frame_sync[1];

  assign take_frame = (state == FETCH_IDLE) && pend_frame;
  assign take_line  = (state == FETCH_IDLE) && !pend_frame && pend_line;
  assign row_inc    = row + 1'b1;

  // ****************************************
  // read loop
  // ****************************************

  always_comb begin
    state_next   = state;
    row_next     = row;
    col_next     = col;
    bank_next    = bank;
    address_next = address;
    wr_en_next   = 1'b0;
    case (state)
      FETCH_IDLE: begin
        if (take_frame) begin
          row_next     = '0;
          bank_next    = 1'b0;
          col_next     = '0;
          address_next = row_address('0);
          state_next   = FETCH_BUS;
        end else if (take_line && (32'(row_inc) < 32'(V_ACTIVE))) begin
          row_next     = row_inc;
          bank_next    = row_inc[0];
          col_next     = '0;
          address_next = row_address(row_inc);
          state_next   = FETCH_BUS;
        end
      end
      FETCH_BUS: begin
        if (!bus_wait) begin  // word taken on this edge
          wr_en_next = 1'b1;
          state_next = FETCH_GRAPHICS;
        end
      end
      FETCH_GRAPHICS: begin
        if (col == LAST_COL) begin
          state_next = FETCH_IDLE;  // row done
        end else begin
          col_next   = col + 1'b1;
          state_next = FETCH_RELEASE;
        end
      end
      FETCH_RELEASE: begin
        address_next = address + PIXEL_BYTES;
        state_next   = FETCH_BUS;
      end
      default: state_next = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge sys_clock or negedge reset_n) begin
    if (!reset_n) begin
      state   <= FETCH_IDLE;
      row     <= '0;
      col     <= '0;
      bank    <= 1'b0;
      address <= '0;
      wr_en   <= 1'b0;
    end else begin
      state   <= state_next;
      row     <= row_next;
      col     <= col_next;
      bank    <= bank_next;
      address <= address_next;
      wr_en   <= wr_en_next;
    end
  end

  always_ff @(posedge sys_clock) begin
    if (state == FETCH_BUS && !bus_wait) wr_pixel <= data;
  end

  assign bus_read = (state == FETCH_BUS) || (state == FETCH_GRAPHICS);
  assign wr_bank  = bank;
  assign wr_col   = col;

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_vga_framebuffer

status=0
./obj_dir/Vtb_vga_framebuffer > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -qF "*** TEST FAILED ***" sim.log; then
  exit 1
fi
exit 0

//--- tb_vga_framebuffer.sv
`timescale 1ns/100ps

module tb_vga_framebuffer
  import vga_pkg::*;
();

  localparam int          H_ACTIVE = 8;
  localparam int          H_FRONT  = 2;
  localparam int          H_SYNC   = 4;
  localparam int          H_BACK   = 10;
  localparam int          V_ACTIVE = 4;
  localparam int          V_FRONT  = 1;
  localparam int          V_SYNC   = 1;
  localparam int          V_BACK   = 1;
  localparam logic [31:0] VIDMEM   = 32'h0010_0000;

  localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int FRAME_WORDS  = H_ACTIVE * V_ACTIVE;
  localparam int GOLDEN_WORDS = FRAME_WORDS + 8;  // pixels, then the 8 timing values
  localparam int RESET_CYCLES = 4;
  localparam int CHECK_FRAMES = 2;
  // 3 frames of 140 ns vga cycles counted in 100 ns sys cycles
  localparam int TIMEOUT_CYCLES = (3 * H_TOTAL * V_TOTAL * 14) / 10 + 200;
  // rows 1 and up after reset, then two whole frames
  localparam int MIN_WORDS = (V_ACTIVE - 1) * H_ACTIVE + CHECK_FRAMES * FRAME_WORDS;

  logic        sys_clock;
  logic        vga_clock;
  logic        reset_n;
  logic        bus_wait;
  rgb_pixel_t  data;
  logic        bus_read;
  logic [31:0] address;
  vga_sync_t   sync;
  rgb_pixel_t  pixel;

  logic [23:0] golden [GOLDEN_WORDS];
  integer      seed = 32'h987d;
  int          value_errors = 0;
  int          other_errors = 0;
  int          words_read = 0;
  int          next_word = H_ACTIVE;  // line 0 fetches row 1 first
  logic        read_taken = 1'b0;
  int          frames_seen = 0;
  int          cycle_count = 0;

  // expected geometry from the golden file
  int          g_h_active;
  int          g_h_sync;
  int          g_h_total;
  int          g_v_active;
  int          g_v_sync;

  // display checker state
  int          row = 0;
  int          col = 0;
  int          hs_gap = 0;
  int          hs_low = 0;
  int          vs_low = 0;
  logic        hs_seen = 1'b0;
  logic        hs_q = 1'b1;
  logic        vs_q = 1'b1;
  logic        blank_q = 1'b0;

  vga_framebuffer #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK),
    .VIDMEM   (VIDMEM)
  ) i_dut (
    .sys_clock (sys_clock),
    .vga_clock (vga_clock),
    .reset_n   (reset_n),
    .bus_wait  (bus_wait),
    .data      (data),
    .bus_read  (bus_read),
    .address   (address),
    .sync      (sync),
    .pixel     (pixel)
  );

  initial begin
    sys_clock = 1'b0;
    forever #50 sys_clock = ~sys_clock;
  end

  initial begin
    vga_clock = 1'b0;
    forever #70 vga_clock = ~vga_clock;
  end

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    value_errors++;
    $display("FAILED %s: expected %0h, actual %0h at %0t", test, expected, actual, $time);
  endtask

  task automatic report_problem(input string what);
    other_errors++;
    $display("ERROR: %s at %0t", what, $time);
  endtask

  task automatic print_summary();
    $display("summary: %0d value errors, %0d other errors, %0d words read, %0d frame ends",
             value_errors, other_errors, words_read, frames_seen);
  endtask

  task automatic load_golden();
    $readmemh("vga_golden.txt", golden);
    g_h_active = int'(golden[FRAME_WORDS]);
    g_h_sync   = int'(golden[FRAME_WORDS + 2]);
    g_h_total  = int'(golden[FRAME_WORDS]) + int'(golden[FRAME_WORDS + 1])
               + int'(golden[FRAME_WORDS + 2]) + int'(golden[FRAME_WORDS + 3]);
    g_v_active = int'(golden[FRAME_WORDS + 4]);
    g_v_sync   = int'(golden[FRAME_WORDS + 6]);
    assert (g_h_active == H_ACTIVE && g_h_total == H_TOTAL && g_h_sync == H_SYNC
            && g_v_active == V_ACTIVE && g_v_sync == V_SYNC)
      else report_problem("timing values in the golden file do not match the DUT parameters");
  endtask

  task automatic check_reset_outputs();
    assert (bus_read == 1'b0) else report_mismatch("reset bus_read", 32'd0, 32'(bus_read));
    assert (sync == SYNC_IDLE) else report_mismatch("reset sync", 32'(SYNC_IDLE), 32'(sync));
    assert (pixel == BLACK) else report_mismatch("reset pixel", 32'(BLACK), 32'(pixel));
  endtask

  // ****************************************
  // video memory model
  // ****************************************

  task automatic drive_memory();
    logic [31:0] offset;
    logic [31:0] roll;
    offset = address - VIDMEM;
    if (bus_read && offset < 32'(4 * FRAME_WORDS)) begin
      data = golden[int'(offset >> 2)];
    end else begin
      data = BLACK;
    end
    roll = $random(seed);
    bus_wait = !bus_wait && roll[0];  // never two wait cycles in a row
  endtask

  initial begin
    data     = BLACK;
    bus_wait = 1'b0;
    forever begin
      @(posedge sys_clock);
      #10 drive_memory();
    end
  end

  task automatic check_bus_word();
    logic [31:0] expected;
    expected = VIDMEM + 32'(4 * next_word);
    assert (address == expected) else report_mismatch("bus address", expected, address);
    assert (address - VIDMEM < 32'(4 * FRAME_WORDS))
      else report_problem("a read was accepted for a row past the last active line");
    words_read++;
    next_word = (next_word + 1) % FRAME_WORDS;  // frame fetch restarts at row 0
  endtask

  // first edge of a bus_read run without bus_wait takes the word
  initial begin
    forever begin
      @(negedge sys_clock);
      if (!reset_n || !bus_read) begin
        read_taken = 1'b0;
      end else if (!bus_wait && !read_taken) begin
        read_taken = 1'b1;
        check_bus_word();
      end
    end
  end

  // ****************************************
  // display checker
  // ****************************************

  task automatic check_display();
    rgb_pixel_t expected;
    hs_gap++;
    if (sync.blank_n) begin
      if (frames_seen >= 1 && row < g_v_active && col < g_h_active) begin
        expected = golden[row * g_h_active + col];
        assert (pixel == expected)
          else report_mismatch("pixel content", 32'(expected), 32'(pixel));
      end
      col++;
    end else begin
      assert (pixel == BLACK) else report_mismatch("blanked pixel", 32'(BLACK), 32'(pixel));
    end
    if (blank_q && !sync.blank_n) begin  // end of an active run
      assert (col == g_h_active)
        else report_mismatch("active run length", 32'(g_h_active), 32'(col));
      row++;
      col = 0;
    end
    if (!sync.hs) hs_low++;
    if (hs_q && !sync.hs) begin
      if (hs_seen) begin
        assert (hs_gap == g_h_total)
          else report_mismatch("hsync period", 32'(g_h_total), 32'(hs_gap));
      end
      hs_gap  = 0;
      hs_seen = 1'b1;
    end
    if (!hs_q && sync.hs) begin
      assert (hs_low == g_h_sync) else report_mismatch("hsync width", 32'(g_h_sync), 32'(hs_low));
      hs_low = 0;
    end
    if (!sync.vs) vs_low++;
    if (!vs_q && sync.vs) begin
      assert (vs_low == g_v_sync * g_h_total)
        else report_mismatch("vsync width", 32'(g_v_sync * g_h_total), 32'(vs_low));
      vs_low = 0;
    end
    if (vs_q && !sync.vs) begin  // new frame
      assert (row == g_v_active)
        else report_mismatch("active lines per frame", 32'(g_v_active), 32'(row));
      row = 0;
      frames_seen++;
    end
    hs_q    = sync.hs;
    vs_q    = sync.vs;
    blank_q = sync.blank_n;
  endtask

  initial begin
    forever begin
      @(negedge vga_clock);
      if (reset_n) check_display();
    end
  end

  initial begin
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge sys_clock);
      cycle_count++;
    end
    report_problem("timeout, the display did not finish the checked frames in time");
    print_summary();
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    reset_n = 1'b1;
    load_golden();
    #1 reset_n = 1'b0;
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge sys_clock);
      #5 check_reset_outputs();
    end
    #5 reset_n = 1'b1;
    wait (frames_seen > CHECK_FRAMES);  // frame 0 row 0 is never fetched
    assert (words_read >= MIN_WORDS)
      else report_problem("fewer words were read from video memory than the rows need");
    print_summary();
    if (value_errors + other_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- vga_framebuffer.sv
`timescale 1ns/100ps

module vga_framebuffer
  import vga_pkg::*;
#(
  parameter int          H_ACTIVE = 640,
  parameter int          H_FRONT  = 16,
  parameter int          H_SYNC   = 96,
  parameter int          H_BACK   = 48,
  parameter int          V_ACTIVE = 480,
  parameter int          V_FRONT  = 10,
  parameter int          V_SYNC   = 2,
  parameter int          V_BACK   = 33,
  parameter logic [31:0] VIDMEM   = 32'h00c00000
) (
  input  logic        sys_clock,
  input  logic        vga_clock,
  input  logic        reset_n,
  input  logic        bus_wait,
  input  rgb_pixel_t  data,
  output logic        bus_read,
  output logic [31:0] address,
  output vga_sync_t   sync,
  output rgb_pixel_t  pixel
);

  localparam int COL_W = $clog2(H_ACTIVE);

  // vga_clock domain
  logic             line_toggle;
  logic             frame_toggle;
  logic             rd_en;
  logic             rd_bank;
  logic [COL_W-1:0] rd_col;

  // sys_clock domain
  logic             wr_en;
  logic             wr_bank;
  logic [COL_W-1:0] wr_col;
  rgb_pixel_t       wr_pixel;

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FRONT  (H_FRONT),
    .H_SYNC   (H_SYNC),
    .H_BACK   (H_BACK),
    .V_ACTIVE (V_ACTIVE),
    .V_FRONT  (V_FRONT),
    .V_SYNC   (V_SYNC),
    .V_BACK   (V_BACK)
  ) i_timing (
    .vga_clock    (vga_clock),
    .reset_n      (reset_n),
    .sync         (sync),
    .line_toggle  (line_toggle),
    .frame_toggle (frame_toggle),
    .rd_bank      (rd_bank),
    .rd_col       (rd_col),
    .rd_en        (rd_en)
  );

  line_fetch #(
    .H_ACTIVE (H_ACTIVE),
    .V_ACTIVE (V_ACTIVE),
    .VIDMEM   (VIDMEM)
  ) i_fetch (
    .sys_clock    (sys_clock),
    .reset_n      (reset_n),
    .line_toggle  (line_toggle),
    .frame_toggle (frame_toggle),
    .bus_wait     (bus_wait),
    .data         (data),
    .bus_read     (bus_read),
    .address      (address),
    .wr_en        (wr_en),
    .wr_bank      (wr_bank),
    .wr_col       (wr_col),
    .wr_pixel     (wr_pixel)
  );

  line_buffer #(
    .H_ACTIVE (H_ACTIVE)
  ) i_buffer (
    .sys_clock (sys_clock),
    .vga_clock (vga_clock),
    .reset_n   (reset_n),
    .wr_en     (wr_en),
    .wr_bank   (wr_bank),
    .wr_col    (wr_col),
    .wr_pixel  (wr_pixel),
    .rd_en     (rd_en),
    .rd_bank   (rd_bank),
    .rd_col    (rd_col),
    .pixel     (pixel)
  );

endmodule

//--- vga_framebuffer_props.sv
`timescale 1ns/100ps

module vga_framebuffer_props
  import vga_pkg::*;
#(
  parameter int H_ACTIVE = 640
) (
  input logic        sys_clock,
  input logic        vga_clock,
  input logic        reset_n,
  input logic        bus_read,
  input logic        bus_wait,
  input logic [31:0] address,
  input vga_sync_t   sync
);

  logic       taken;     // word of this bus_read run already accepted
  logic       accept;
  logic       stall;
  logic       accept_q;
  logic [1:0] more_q;    // more words of the row follow
  int         words;

  assign accept = bus_read && !taken && !bus_wait;
  assign stall  = bus_read && !taken && bus_wait;

  always_ff @(posedge sys_clock or negedge reset_n) begin
    if (!reset_n) begin
      taken    <= 1'b0;
      accept_q <= 1'b0;
      more_q   <= '0;
      words    <= 0;
    end else begin
      if (!bus_read) begin
        taken <= 1'b0;
      end else if (accept) begin
        taken <= 1'b1;
      end
      accept_q <= accept;
      more_q   <= {more_q[0], accept && (words != H_ACTIVE - 1)};
      if (accept) words <= (words == H_ACTIVE - 1) ? 0 : words + 1;
    end
  end

  // ****************************************
  // bus strobes
  // ****************************************

  a_stall_holds: assert property (@(posedge sys_clock) disable iff (!reset_n)
    stall |=> (bus_read && $stable(address)))
    else $error("address or bus_read moved during a bus_wait stall");

  a_graphics_cycle: assert property (@(posedge sys_clock) disable iff (!reset_n)
    accept |=> bus_read)
    else $error("bus_read dropped in the graphics cycle");

  a_release_cycle: assert property (@(posedge sys_clock) disable iff (!reset_n)
    accept_q |=> !bus_read)
    else $error("no release cycle after an accepted word");

  a_next_word: assert property (@(posedge sys_clock) disable iff (!reset_n)
    more_q[1] |=> bus_read)  // release lasts one cycle
    else $error("release longer than one cycle inside a row");

  a_hs_blanked: assert property (@(posedge vga_clock) disable iff (!reset_n)
    !sync.hs |-> !sync.blank_n)
    else $error("hsync active while the display is not blanked");

endmodule

bind vga_framebuffer vga_framebuffer_props #(
  .H_ACTIVE (H_ACTIVE)
) i_props (
  .sys_clock (sys_clock),
  .vga_clock (vga_clock),
  .reset_n   (reset_n),
  .bus_read  (bus_read),
  .bus_wait  (bus_wait),
  .address   (address),
  .sync      (sync)
);

//--- vga_golden.txt
// 32 pixel words rrggbb, row 0 col 0 first, then the timing values
// H_ACTIVE H_FRONT H_SYNC H_BACK V_ACTIVE V_FRONT V_SYNC V_BACK
10ff03
11fe0b
12fd13
13fc1b
14fb23
15fa2b
16f933
17f83b
20f743
21f64b
22f553
23f45b
24f363
25f26b
26f173
27f07b
30ef83
31ee8b
32ed93
33ec9b
34eba3
35eaab
36e9b3
37e8bb
40e7c3
41e6cb
42e5d3
43e4db
44e3e3
45e2eb
46e1f3
47e0fb
08 02 04 0a 04 01 01 01

//--- vga_pkg.sv
package vga_pkg;

  // ****************************************
  // pixel and display control words
  // ****************************************

  // one bus word, one line buffer entry, one display pixel
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_pixel_t;

  // display control, hs and vs active low
  typedef struct packed {
    logic hs;
    logic vs;
    logic blank_n;
  } vga_sync_t;

  localparam rgb_pixel_t BLACK = '{r: 8'h00, g: 8'h00, b: 8'h00};

  // syncs inactive, screen blanked
  localparam vga_sync_t SYNC_IDLE = '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0};

  // ****************************************
  // fetch engine
  // ****************************************

  // read loop, one release cycle between words
  typedef enum logic [1:0] {
    FETCH_IDLE     = 2'd0,
    FETCH_BUS      = 2'd1,  // bus_read up, waiting out bus_wait
    FETCH_GRAPHICS = 2'd2,  // word taken, written to line buffer
    FETCH_RELEASE  = 2'd3   // bus_read low for one cycle
  } fetch_state_t;

  // byte step per pixel in video memory
  localparam int unsigned PIXEL_BYTES = 4;

endpackage

//--- vga_timing.sv
`timescale 1ns/100ps

module vga_timing
  import vga_pkg::*;
#(
  parameter int H_ACTIVE = 640,
  parameter int H_FRONT  = 16,
  parameter int H_SYNC   = 96,
  parameter int H_BACK   = 48,
  parameter int V_ACTIVE = 480,
  parameter int V_FRONT  = 10,
  parameter int V_SYNC   = 2,
  parameter int V_BACK   = 33
) (
  input  logic                        vga_clock,
  input  logic                        reset_n,
  output vga_sync_t                   sync,
  output logic                        line_toggle,
  output logic                        frame_toggle,
  output logic                        rd_bank,
  output logic [$clog2(H_ACTIVE)-1:0] rd_col,
  output logic                        rd_en
);

  localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
  localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
  localparam int H_W      = $clog2(H_TOTAL);
  localparam int V_W      = $clog2(V_TOTAL);
  localparam int COL_W    = $clog2(H_ACTIVE);
  localparam int HS_START = H_ACTIVE + H_FRONT;
  localparam int VS_START = V_ACTIVE + V_FRONT;

  logic [H_W-1:0] h_count;
  logic [V_W-1:0] v_count;
  logic           h_last;
  logic           v_last;
  logic           active;
  logic           hs_zone;
  logic           vs_zone;
  logic           line_start;
  logic           vblank_start;

  assign h_last = (h_count == H_W'(H_TOTAL - 1));
  assign v_last = (v_count == V_W'(V_TOTAL - 1));

  assign active  = (h_count < H_W'(H_ACTIVE)) && (v_count < V_W'(V_ACTIVE));
  assign hs_zone = (h_count >= H_W'(HS_START)) && (h_count < H_W'(HS_START + H_SYNC));
  assign vs_zone = (v_count >= V_W'(VS_START)) && (v_count < V_W'(VS_START + V_SYNC));

  assign line_start   = (h_count == '0) && (v_count < V_W'(V_ACTIVE));
  assign vblank_start = (h_count == '0) && (v_count == V_W'(V_ACTIVE));

  // lookahead read request, one cycle before sync
  assign rd_en   = active;
  assign rd_bank = v_count[0];  // row y lives in bank y mod 2
  assign rd_col  = h_count[COL_W-1:0];

  always_ff @(posedge vga_clock or negedge reset_n) begin
    if (!reset_n) begin
      h_count <= '0;
      v_count <= '0;
    end else if (h_last) begin
      h_count <= '0;
      v_count <= v_last ? '0 : v_count + 1'b1;
    end else begin
      h_count <= h_count + 1'b1;
    end
  end

  // ****************************************
  // registered outputs
  // ****************************************

  always_ff @(posedge vga_clock or negedge reset_n) begin
    if (!reset_n) begin
      sync         <= SYNC_IDLE;
      line_toggle  <= 1'b0;
      frame_toggle <= 1'b0;
    end else begin
      sync.hs      <= !hs_zone;
      sync.vs      <= !vs_zone;
      sync.blank_n <= active;
      line_toggle  <= line_toggle ^ line_start;     // every active line
      frame_toggle <= frame_toggle ^ vblank_start;  // vertical blank begins
    end
  end

endmodule
